//--- sim.f
tracker_pkg.sv
video_timing.sv
downscale_writer.sv
frame_buffer.sv
pixel_classifier.sv
delay_line.sv
overlay_mux.sv
tracker_display_top.sv
tb_tracker_display.sv

//--- tb_tracker_display.sv
`default_nettype none

module tb_tracker_display import tracker_pkg::*;;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int H_ACTIVE = 32;
    localparam int H_FP     = 2;
    localparam int H_SYNC   = 4;
    localparam int H_BP     = 2;
    localparam int V_ACTIVE = 16;
    localparam int V_FP     = 1;
    localparam int V_SYNC   = 2;
    localparam int V_BP     = 1;
    localparam int H_TOTAL  = H_ACTIVE + H_FP + H_SYNC + H_BP;
    localparam int V_TOTAL  = V_ACTIVE + V_FP + V_SYNC + V_BP;
    localparam int HCW      = $clog2(H_TOTAL);
    localparam int VCW      = $clog2(V_TOTAL);
    localparam int CCW      = $clog2(H_ACTIVE);
    localparam int CRW      = $clog2(V_ACTIVE);
    localparam int FB_W     = H_ACTIVE / 4;
    localparam int FB_DEPTH = FB_W * (V_ACTIVE / 4);
    localparam int LATENCY  = 3;
    localparam int FRAME_CYCLES   = H_TOTAL * V_TOTAL;
    // first pulse comes within one frame and five test frames follow
    localparam int TIMEOUT_CYCLES = 6 * FRAME_CYCLES + 400;

    logic           clk_pixel;
    logic           recent_reset;
    logic           pixel_valid;
    logic [CCW-1:0] pixel_h;
    logic [CRW-1:0] pixel_v;
    rgb565_t        pixel_data;
    logic [3:0]     lower_nibble;
    logic [3:0]     upper_nibble;
    logic           target_sel;
    logic           bg_sel;
    logic [HCW-1:0] cross_x;
    logic [VCW-1:0] cross_y;
    logic [HCW-1:0] hcount_o;
    logic [VCW-1:0] vcount_o;
    logic           hsync_o;
    logic           vsync_o;
    logic           active_draw_o;
    logic           new_frame_o;
    logic [7:0]     red_o;
    logic [7:0]     green_o;
    logic [7:0]     blue_o;

    // reference position and the same position LATENCY cycles later
    int             ref_h;
    int             ref_v;
    logic [HCW-1:0] pipe_h [LATENCY];
    logic [VCW-1:0] pipe_v [LATENCY];
    logic           pipe_ok [LATENCY];
    logic [HCW-1:0] out_h;
    logic [VCW-1:0] out_v;
    logic           out_ok;
    logic           exp_active;
    logic           exp_hsync;
    logic           exp_vsync;
    logic           exp_new_frame;

    rgb565_t     model_mem [FB_DEPTH];
    logic        colour_chk;
    logic [31:0] rng_state;
    int          err_count;
    int          err_mark;
    int          test_count;
    int          failed_tests;
    int          cycle_count;

    tracker_display_top #(
        .H_ACTIVE(H_ACTIVE), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
        .V_ACTIVE(V_ACTIVE), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP)
    ) UUT (
        .clk_pixel(clk_pixel),
        .recent_reset(recent_reset),
        .pixel_valid_i(pixel_valid),
        .pixel_hcount_i(pixel_h),
        .pixel_vcount_i(pixel_v),
        .pixel_data_i(pixel_data),
        .lower_nibble_i(lower_nibble),
        .upper_nibble_i(upper_nibble),
        .target_sel_i(target_sel),
        .bg_sel_i(bg_sel),
        .cross_x_i(cross_x),
        .cross_y_i(cross_y),
        .hcount_o(hcount_o),
        .vcount_o(vcount_o),
        .hsync_o(hsync_o),
        .vsync_o(vsync_o),
        .active_draw_o(active_draw_o),
        .new_frame_o(new_frame_o),
        .red_o(red_o),
        .green_o(green_o),
        .blue_o(blue_o)
    );

    initial begin
        clk_pixel = 1'b0;
        forever #2 clk_pixel = ~clk_pixel;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // expected display colour at an output position
    function automatic logic [23:0] expected_rgb(input logic ok, input int h, input int v);
        rgb565_t    s;
        logic [7:0] r8;
        logic [7:0] g8;
        logic [7:0] b8;
        int         y;
        logic       in_window;
        if (!ok || h >= H_ACTIVE || v >= V_ACTIVE) begin
            return 24'h000000;
        end
        if (h == cross_x || v == cross_y) begin
            return 24'h00ff00;
        end
        s  = model_mem[(h / 4) + (v / 4) * FB_W];
        r8 = {s.r, 3'b000};
        g8 = {s.g, 2'b00};
        b8 = {s.b, 3'b000};
        if (!target_sel) begin
            return {r8, g8, b8};
        end
        y = (77 * r8 + 150 * g8 + 29 * b8) / 256;
        in_window = (y > {lower_nibble, 4'h0}) && (y <= {upper_nibble, 4'hf});
        if (in_window) begin
            return 24'hffffff;
        end
        if (bg_sel) begin
            return {y[7:0], y[7:0], y[7:0]};
        end
        return 24'h000000;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("Fail %s: got %h expected %h at %0t", name, got, exp, $time);
        err_count++;
    endtask

    // model of the frame position as the outputs should show it
    always @(posedge clk_pixel) begin
        if (recent_reset) begin
            ref_h <= 0;
            ref_v <= 0;
            for (int i = 0; i < LATENCY; i++) begin
                pipe_h[i]  <= '0;
                pipe_v[i]  <= '0;
                pipe_ok[i] <= 1'b0;
            end
        end else begin
            ref_h <= (ref_h + 1) % H_TOTAL;
            if (ref_h == H_TOTAL - 1) begin
                ref_v <= (ref_v + 1) % V_TOTAL;
            end
            pipe_h[0]  <= HCW'(ref_h);
            pipe_v[0]  <= VCW'(ref_v);
            pipe_ok[0] <= 1'b1;
            for (int i = 1; i < LATENCY; i++) begin
                pipe_h[i]  <= pipe_h[i-1];
                pipe_v[i]  <= pipe_v[i-1];
                pipe_ok[i] <= pipe_ok[i-1];
            end
        end
    end

    assign out_h  = pipe_h[LATENCY-1];
    assign out_v  = pipe_v[LATENCY-1];
    assign out_ok = pipe_ok[LATENCY-1];
    assign exp_active    = out_ok && (out_h < H_ACTIVE) && (out_v < V_ACTIVE);
    assign exp_hsync     = out_ok && (out_h >= H_ACTIVE + H_FP)
                        && (out_h < H_ACTIVE + H_FP + H_SYNC);
    assign exp_vsync     = out_ok && (out_v >= V_ACTIVE + V_FP)
                        && (out_v < V_ACTIVE + V_FP + V_SYNC);
    assign exp_new_frame = out_ok && (out_h == H_ACTIVE) && (out_v == V_ACTIVE);

    a_hcount: assert property (@(posedge clk_pixel) disable iff (recent_reset)
        hcount_o == out_h)
        else report_mismatch("hcount_o", $sampled(hcount_o), $sampled(out_h));
    a_vcount: assert property (@(posedge clk_pixel) disable iff (recent_reset)
        vcount_o == out_v)
        else report_mismatch("vcount_o", $sampled(vcount_o), $sampled(out_v));
    a_hsync: assert property (@(posedge clk_pixel) disable iff (recent_reset)
        hsync_o == exp_hsync)
        else report_mismatch("hsync_o", $sampled(hsync_o), $sampled(exp_hsync));
    a_vsync: assert property (@(posedge clk_pixel) disable iff (recent_reset)
        vsync_o == exp_vsync)
        else report_mismatch("vsync_o", $sampled(vsync_o), $sampled(exp_vsync));
    a_active: assert property (@(posedge clk_pixel) disable iff (recent_reset)
        active_draw_o == exp_active)
        else report_mismatch("active_draw_o", $sampled(active_draw_o), $sampled(exp_active));
    a_new_frame: assert property (@(posedge clk_pixel) disable iff (recent_reset)
        new_frame_o == exp_new_frame)
        else report_mismatch("new_frame_o", $sampled(new_frame_o), $sampled(exp_new_frame));
    a_blank: assert property (@(posedge clk_pixel) disable iff (recent_reset)
        !exp_active |-> {red_o, green_o, blue_o} == 24'h000000)
        else report_mismatch("rgb blank", $sampled({red_o, green_o, blue_o}), 0);
    a_cross: assert property (@(posedge clk_pixel) disable iff (recent_reset)
        (exp_active && (out_h == cross_x || out_v == cross_y))
        |-> {red_o, green_o, blue_o} == 24'h00ff00)
        else report_mismatch("rgb cross", $sampled({red_o, green_o, blue_o}), 24'h00ff00);
    a_rgb: assert property (@(posedge clk_pixel) disable iff (recent_reset || !colour_chk)
        {red_o, green_o, blue_o} == expected_rgb(out_ok, out_h, out_v))
        else report_mismatch("rgb", $sampled({red_o, green_o, blue_o}),
                             expected_rgb($sampled(out_ok), $sampled(out_h), $sampled(out_v)));

    always @(posedge clk_pixel) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Checks failed");
            $finish;
        end
    end

    // one full raster of camera pixels with the aligned ones optionally skipped
    task automatic send_camera_frame(input bit write_aligned);
        int          addr;
        bit          aligned;
        logic [15:0] value;
        for (int v = 0; v < V_ACTIVE; v++) begin
            for (int h = 0; h < H_ACTIVE; h++) begin
                @(posedge clk_pixel);
                #1;
                addr      = (h / 4) + (v / 4) * FB_W;
                aligned   = (h % 4 == 0) && (v % 4 == 0);
                rng_state = xorshift32(rng_state);
                value     = rng_state[15:0];
                if (!aligned && value == model_mem[addr]) begin
                    value = ~value;
                end
                pixel_h     = CCW'(h);
                pixel_v     = CRW'(v);
                pixel_data  = value;
                pixel_valid = !aligned || write_aligned;
                if (aligned && write_aligned) begin
                    model_mem[addr] = value;
                end
            end
        end
        @(posedge clk_pixel);
        #1;
        pixel_valid = 1'b0;
    endtask

    task automatic wait_new_frame();
        bit seen;
        seen = 1'b0;
        for (int i = 0; i < FRAME_CYCLES + 20 && !seen; i++) begin
            @(negedge clk_pixel);
            seen = new_frame_o;
        end
        if (!seen) begin
            $display("new_frame_o did not pulse within one frame");
            err_count++;
        end
        @(posedge clk_pixel);
        #1;
    endtask

    task automatic finish_test(input string name);
        int fails;
        fails = err_count - err_mark;
        test_count++;
        if (fails != 0) begin
            failed_tests++;
        end
        $display("test %0d %s: %s, %0d mismatches", test_count, name,
                 (fails == 0) ? "ok" : "FAILED", fails);
        err_mark = err_count;
    endtask

    initial begin
        recent_reset = 1'b1;
        pixel_valid  = 1'b0;
        pixel_h      = '0;
        pixel_v      = '0;
        pixel_data   = '0;
        lower_nibble = 4'h0;
        upper_nibble = 4'h0;
        target_sel   = 1'b0;
        bg_sel       = 1'b0;
        // both lines off screen
        cross_x      = '1;
        cross_y      = '1;
        colour_chk   = 1'b0;
        rng_state    = 32'd16186;
        err_count    = 0;
        err_mark     = 0;
        test_count   = 0;
        failed_tests = 0;
        cycle_count  = 0;
        repeat (4) @(posedge clk_pixel);
        #1;
        recent_reset = 1'b0;

        send_camera_frame(1'b1);
        wait_new_frame();
        finish_test("frame timing");

        colour_chk = 1'b1;
        wait_new_frame();
        finish_test("camera view");

        // only non-aligned pixels that differ from the stored samples
        send_camera_frame(1'b0);
        wait_new_frame();
        finish_test("non-aligned pixels dropped");

        target_sel   = 1'b1;
        lower_nibble = 4'h4;
        upper_nibble = 4'ha;
        wait_new_frame();
        bg_sel = 1'b1;
        wait_new_frame();
        finish_test("threshold view");

        target_sel = 1'b0;
        cross_x    = HCW'(5);
        cross_y    = VCW'(9);
        // switch views halfway down the frame
        repeat (FRAME_CYCLES / 2) @(posedge clk_pixel);
        #1;
        target_sel = 1'b1;
        wait_new_frame();
        finish_test("crosshair");

        $display("tests %0d, tests with mismatches %0d, mismatches %0d",
                 test_count, failed_tests, err_count);
        if (err_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tracker_display_top.sv
`default_nettype none

module tracker_display_top import tracker_pkg::*; #(
    parameter int H_ACTIVE = DEF_H_ACTIVE,
    parameter int H_FP     = DEF_H_FP,
    parameter int H_SYNC   = DEF_H_SYNC,
    parameter int H_BP     = DEF_H_BP,
    parameter int V_ACTIVE = DEF_V_ACTIVE,
    parameter int V_FP     = DEF_V_FP,
    parameter int V_SYNC   = DEF_V_SYNC,
    parameter int V_BP     = DEF_V_BP,
    localparam int HCW     = $clog2(H_ACTIVE + H_FP + H_SYNC + H_BP),
    localparam int VCW     = $clog2(V_ACTIVE + V_FP + V_SYNC + V_BP),
    localparam int CCW     = $clog2(H_ACTIVE),
    localparam int CRW     = $clog2(V_ACTIVE)
) (
    input  wire            clk_pixel,
    input  wire            recent_reset,
    // camera pixels arrive in the clk_pixel domain
    input  wire            pixel_valid_i,
    input  wire  [CCW-1:0] pixel_hcount_i,
    input  wire  [CRW-1:0] pixel_vcount_i,
    input  rgb565_t        pixel_data_i,
    input  wire  [3:0]     lower_nibble_i,
    input  wire  [3:0]     upper_nibble_i,
    input  wire            target_sel_i,
    input  wire            bg_sel_i,
    input  wire  [HCW-1:0] cross_x_i,
    input  wire  [VCW-1:0] cross_y_i,
    output logic [HCW-1:0] hcount_o,
    output logic [VCW-1:0] vcount_o,
    output logic           hsync_o,
    output logic           vsync_o,
    output logic           active_draw_o,
    output logic           new_frame_o,
    output logic [7:0]     red_o,
    output logic [7:0]     green_o,
    output logic [7:0]     blue_o
);

    localparam int AW = $clog2((H_ACTIVE >> SCALE_SHIFT) * (V_ACTIVE >> SCALE_SHIFT));

    typedef struct packed {
        logic [HCW-1:0] h;
        logic [VCW-1:0] v;
    } count_t;

    typedef struct packed {
        logic hsync;
        logic vsync;
        logic active;
        logic new_frame;
    } ctrl_t;

    logic [HCW-1:0] hcount;
    logic [VCW-1:0] vcount;
    logic           hsync;
    logic           vsync;
    logic           active_draw;
    logic           new_frame;

    logic           wr_en;
    logic [AW-1:0]  wr_addr;
    rgb565_t        wr_data;
    rgb565_t        fb_pixel;

    rgb888_t        cls_pixel;
    logic [7:0]     cls_luma;
    logic           cls_mask;

    count_t         count_s0;
    count_t         count_s3;
    ctrl_t          ctrl_s0;
    ctrl_t          ctrl_s3;

    video_timing #(
        .H_ACTIVE(H_ACTIVE), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
        .V_ACTIVE(V_ACTIVE), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP)
    ) u_timing (
        .clk_pixel(clk_pixel),
        .recent_reset(recent_reset),
        .hcount_o(hcount),
        .vcount_o(vcount),
        .hsync_o(hsync),
        .vsync_o(vsync),
        .active_draw_o(active_draw),
        .new_frame_o(new_frame)
    );

    downscale_writer #(
        .H_ACTIVE(H_ACTIVE),
        .V_ACTIVE(V_ACTIVE)
    ) u_writer (
        .clk_pixel(clk_pixel),
        .recent_reset(recent_reset),
        .pixel_valid_i(pixel_valid_i),
        .pixel_hcount_i(pixel_hcount_i),
        .pixel_vcount_i(pixel_vcount_i),
        .pixel_data_i(pixel_data_i),
        .wr_en_o(wr_en),
        .wr_addr_o(wr_addr),
        .wr_data_o(wr_data)
    );

    // stages 1 and 2 of the display pipeline
    frame_buffer #(
        .H_ACTIVE(H_ACTIVE),
        .V_ACTIVE(V_ACTIVE),
        .HCW(HCW),
        .VCW(VCW)
    ) u_fb (
        .clk_pixel(clk_pixel),
        .wr_en_i(wr_en),
        .wr_addr_i(wr_addr),
        .wr_data_i(wr_data),
        .hcount_i(hcount),
        .vcount_i(vcount),
        .rd_data_o(fb_pixel)
    );

    // stage 3
    pixel_classifier u_classifier (
        .clk_pixel(clk_pixel),
        .pixel_i(fb_pixel),
        .lower_nibble_i(lower_nibble_i),
        .upper_nibble_i(upper_nibble_i),
        .pixel_o(cls_pixel),
        .luma_o(cls_luma),
        .mask_o(cls_mask)
    );

    // counts and control ride alongside the pixel to stage 3
    assign count_s0 = '{h: hcount, v: vcount};
    assign ctrl_s0  = '{hsync: hsync, vsync: vsync, active: active_draw, new_frame: new_frame};

    delay_line #(
        .DEPTH(PIPE_DELAY),
        .payload_t(count_t)
    ) u_count_delay (
        .clk_pixel(clk_pixel),
        .recent_reset(recent_reset),
        .data_i(count_s0),
        .data_o(count_s3)
    );

    delay_line #(
        .DEPTH(PIPE_DELAY),
        .payload_t(ctrl_t)
    ) u_ctrl_delay (
        .clk_pixel(clk_pixel),
        .recent_reset(recent_reset),
        .data_i(ctrl_s0),
        .data_o(ctrl_s3)
    );

    overlay_mux #(
        .HCW(HCW),
        .VCW(VCW)
    ) u_mux (
        .pixel_i(cls_pixel),
        .luma_i(cls_luma),
        .mask_i(cls_mask),
        .active_i(ctrl_s3.active),
        .target_sel_i(target_sel_i),
        .bg_sel_i(bg_sel_i),
        .hcount_i(count_s3.h),
        .vcount_i(count_s3.v),
        .cross_x_i(cross_x_i),
        .cross_y_i(cross_y_i),
        .red_o(red_o),
        .green_o(green_o),
        .blue_o(blue_o)
    );

    assign hcount_o      = count_s3.h;
    assign vcount_o      = count_s3.v;
    assign hsync_o       = ctrl_s3.hsync;
    assign vsync_o       = ctrl_s3.vsync;
    assign active_draw_o = ctrl_s3.active;
    assign new_frame_o   = ctrl_s3.new_frame;

endmodule

`default_nettype wire

//--- overlay_mux.sv
`default_nettype none

module overlay_mux import tracker_pkg::*; #(
    parameter int HCW = $clog2(DEF_H_ACTIVE + DEF_H_FP + DEF_H_SYNC + DEF_H_BP),
    parameter int VCW = $clog2(DEF_V_ACTIVE + DEF_V_FP + DEF_V_SYNC + DEF_V_BP)
) (
    input  rgb888_t        pixel_i,
    input  wire  [7:0]     luma_i,
    input  wire            mask_i,
    input  wire            active_i,
    input  wire            target_sel_i,
    input  wire            bg_sel_i,
    input  wire  [HCW-1:0] hcount_i,
    input  wire  [VCW-1:0] vcount_i,
    input  wire  [HCW-1:0] cross_x_i,
    input  wire  [VCW-1:0] cross_y_i,
    output logic [7:0]     red_o,
    output logic [7:0]     green_o,
    output logic [7:0]     blue_o
);

    rgb888_t pix;
    logic    on_cross;

    assign on_cross = (hcount_i == cross_x_i) || (vcount_i == cross_y_i);

    // crosshair wins over both views
    always_comb begin
        if (!active_i) begin
            pix = '0;
        end else if (on_cross) begin
            pix = CROSS_COLOR;
        end else if (!target_sel_i) begin
            pix = pixel_i;
        end else if (mask_i) begin
            pix = '{r: 8'hff, g: 8'hff, b: 8'hff};
        end else if (bg_sel_i) begin
            // gray background from the luma
            pix = '{r: luma_i, g: luma_i, b: luma_i};
        end else begin
            pix = '0;
        end
    end

    assign red_o   = pix.r;
    assign green_o = pix.g;
    assign blue_o  = pix.b;

endmodule

`default_nettype wire

//--- delay_line.sv
`default_nettype none

module delay_line import tracker_pkg::*; #(
    parameter int  DEPTH     = PIPE_DELAY,
    parameter type payload_t = logic
) (
    input  wire      clk_pixel,
    input  wire      recent_reset,
    input  payload_t data_i,
    output payload_t data_o
);

    payload_t stages [DEPTH];

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                stages[i] <= '0;
            end
        end else begin
            stages[0] <= data_i;
            for (int i = 1; i < DEPTH; i++) begin
                stages[i] <= stages[i-1];
            end
        end
    end

    assign data_o = stages[DEPTH-1];

endmodule

`default_nettype wire

//--- pixel_classifier.sv
`default_nettype none

module pixel_classifier import tracker_pkg::*; (
    input  wire        clk_pixel,
    input  rgb565_t    pixel_i,
    input  wire  [3:0] lower_nibble_i,
    input  wire  [3:0] upper_nibble_i,
    output rgb888_t    pixel_o,
    output logic [7:0] luma_o,
    output logic       mask_o
);

    rgb888_t     expanded;
    logic [15:0] luma_sum;
    logic [7:0]  luma;
    logic [7:0]  lower_thresh;
    logic [7:0]  upper_thresh;

    // low bits are zero filled, not replicated
    assign expanded.r = {pixel_i.r, 3'b000};
    assign expanded.g = {pixel_i.g, 2'b00};
    assign expanded.b = {pixel_i.b, 3'b000};

    // weights sum to 256, so the top byte is the luma
    assign luma_sum = 16'd77 * expanded.r + 16'd150 * expanded.g + 16'd29 * expanded.b;
    assign luma     = luma_sum[15:8];

    assign lower_thresh = {lower_nibble_i, 4'b0000};
    assign upper_thresh = {upper_nibble_i, 4'b1111};

    always_ff @(posedge clk_pixel) begin
        pixel_o <= expanded;
        luma_o  <= luma;
        // open at the bottom, closed at the top
        mask_o  <= (luma > lower_thresh) && (luma <= upper_thresh);
    end

endmodule

`default_nettype wire

//--- frame_buffer.sv
`default_nettype none

module frame_buffer import tracker_pkg::*; #(
    parameter int H_ACTIVE  = DEF_H_ACTIVE,
    parameter int V_ACTIVE  = DEF_V_ACTIVE,
    parameter int HCW       = $clog2(DEF_H_ACTIVE + DEF_H_FP + DEF_H_SYNC + DEF_H_BP),
    parameter int VCW       = $clog2(DEF_V_ACTIVE + DEF_V_FP + DEF_V_SYNC + DEF_V_BP),
    localparam int FB_W     = H_ACTIVE >> SCALE_SHIFT,
    localparam int FB_H     = V_ACTIVE >> SCALE_SHIFT,
    localparam int FB_DEPTH = FB_W * FB_H,
    localparam int AW       = $clog2(FB_DEPTH)
) (
    input  wire            clk_pixel,
    input  wire            wr_en_i,
    input  wire  [AW-1:0]  wr_addr_i,
    input  rgb565_t        wr_data_i,
    input  wire  [HCW-1:0] hcount_i,
    input  wire  [VCW-1:0] vcount_i,
    output rgb565_t        rd_data_o
);

    rgb565_t       mem [FB_DEPTH];
    logic [AW-1:0] rd_addr;
    logic          in_frame;

    assign in_frame = (hcount_i < H_ACTIVE) && (vcount_i < V_ACTIVE);

    // each stored sample covers a 4x4 block of display pixels
    // blanking reads park on address 0
    always_ff @(posedge clk_pixel) begin
        if (in_frame) begin
            rd_addr <= AW'((hcount_i >> SCALE_SHIFT) + (vcount_i >> SCALE_SHIFT) * FB_W);
        end else begin
            rd_addr <= '0;
        end
    end

    // read-first on a same-address collision
    always_ff @(posedge clk_pixel) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
        rd_data_o <= mem[rd_addr];
    end

endmodule

`default_nettype wire

//--- downscale_writer.sv
`default_nettype none

module downscale_writer import tracker_pkg::*; #(
    parameter int H_ACTIVE  = DEF_H_ACTIVE,
    parameter int V_ACTIVE  = DEF_V_ACTIVE,
    localparam int CCW      = $clog2(H_ACTIVE),
    localparam int CRW      = $clog2(V_ACTIVE),
    localparam int FB_W     = H_ACTIVE >> SCALE_SHIFT,
    localparam int FB_DEPTH = FB_W * (V_ACTIVE >> SCALE_SHIFT),
    localparam int AW       = $clog2(FB_DEPTH)
) (
    input  wire            clk_pixel,
    input  wire            recent_reset,
    input  wire            pixel_valid_i,
    input  wire  [CCW-1:0] pixel_hcount_i,
    input  wire  [CRW-1:0] pixel_vcount_i,
    input  rgb565_t        pixel_data_i,
    output logic           wr_en_o,
    output logic [AW-1:0]  wr_addr_o,
    output rgb565_t        wr_data_o
);

    logic keep;

    // only one pixel out of each 4x4 block reaches the buffer
    assign keep = pixel_valid_i
               && (pixel_hcount_i[SCALE_SHIFT-1:0] == '0)
               && (pixel_vcount_i[SCALE_SHIFT-1:0] == '0);

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            wr_en_o <= 1'b0;
        end else begin
            wr_en_o <= keep;
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (keep) begin
            wr_addr_o <= AW'((pixel_hcount_i >> SCALE_SHIFT)
                           + (pixel_vcount_i >> SCALE_SHIFT) * FB_W);
            wr_data_o <= pixel_data_i;
        end
    end

endmodule

`default_nettype wire

//--- video_timing.sv
`default_nettype none

module video_timing import tracker_pkg::*; #(
    parameter int H_ACTIVE = DEF_H_ACTIVE,
    parameter int H_FP     = DEF_H_FP,
    parameter int H_SYNC   = DEF_H_SYNC,
    parameter int H_BP     = DEF_H_BP,
    parameter int V_ACTIVE = DEF_V_ACTIVE,
    parameter int V_FP     = DEF_V_FP,
    parameter int V_SYNC   = DEF_V_SYNC,
    parameter int V_BP     = DEF_V_BP,
    localparam int H_TOTAL = H_ACTIVE + H_FP + H_SYNC + H_BP,
    localparam int V_TOTAL = V_ACTIVE + V_FP + V_SYNC + V_BP,
    localparam int HCW     = $clog2(H_TOTAL),
    localparam int VCW     = $clog2(V_TOTAL)
) (
    input  wire            clk_pixel,
    input  wire            recent_reset,
    output logic [HCW-1:0] hcount_o,
    output logic [VCW-1:0] vcount_o,
    output logic           hsync_o,
    output logic           vsync_o,
    output logic           active_draw_o,
    output logic           new_frame_o
);

    logic h_last;
    logic v_last;

    assign h_last = (hcount_o == HCW'(H_TOTAL - 1));
    assign v_last = (vcount_o == VCW'(V_TOTAL - 1));

    // vertical count advances once per line
    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            hcount_o <= '0;
            vcount_o <= '0;
        end else if (h_last) begin
            hcount_o <= '0;
            vcount_o <= v_last ? '0 : vcount_o + 1'b1;
        end else begin
            hcount_o <= hcount_o + 1'b1;
        end
    end

    // sync pulses sit between the front and back porch
    assign hsync_o = (hcount_o >= H_ACTIVE + H_FP) && (hcount_o < H_ACTIVE + H_FP + H_SYNC);
    assign vsync_o = (vcount_o >= V_ACTIVE + V_FP) && (vcount_o < V_ACTIVE + V_FP + V_SYNC);

    assign active_draw_o = (hcount_o < H_ACTIVE) && (vcount_o < V_ACTIVE);

    // first blanking pixel after the last active line
    assign new_frame_o = (hcount_o == H_ACTIVE) && (vcount_o == V_ACTIVE);

endmodule

`default_nettype wire

//--- tracker_pkg.sv
`default_nettype none

package tracker_pkg;

    // camera pixel as stored in the frame buffer
    typedef struct packed {
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
    } rgb565_t;

    // display pixel, 8 bits per channel
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb888_t;

    // 720p timing
    localparam int DEF_H_ACTIVE = 1280;
    localparam int DEF_H_FP     = 110;
    localparam int DEF_H_SYNC   = 40;
    localparam int DEF_H_BP     = 220;
    localparam int DEF_V_ACTIVE = 720;
    localparam int DEF_V_FP     = 5;
    localparam int DEF_V_SYNC   = 5;
    localparam int DEF_V_BP     = 20;

    // 4x scaling in each direction
    localparam int SCALE_SHIFT = 2;

    // address reg, memory read, classifier reg
    localparam int PIPE_DELAY = 3;

    localparam rgb888_t CROSS_COLOR = '{r: 8'h00, g: 8'hff, b: 8'h00};

endpackage

`default_nettype wire
